// ==== tb.f ====
+incdir+rtl
+incdir+verif
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/instrQueue.sv
rtl/instrDecode.sv
rtl/regFile.sv
rtl/aluExec.sv
rtl/cpuCore.sv
verif/cpuCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the cpuCore testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module cpuCoreTb -f tb.f -o cpuCoreSim \
	&& ./obj_dir/cpuCoreSim > sim.log 2>&1 \
	|| echo "Build or simulation did not complete" >> sim.log
cat sim.log
! grep -q "TEST FAILED" sim.log && grep -q "TEST PASSED" sim.log

// ==== verif/refModel.svh ====
/*
 * Reference model of the core ISA that the testbench includes
 * Builds the queue of expected writebacks in push order
 */
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

logic [15:0] modelRegs [16];
logic        modelFlag;
logic        modelHalted;
// Register address in the top nibble, data below
logic [19:0] expQ [$];

task automatic modelReset();
	for (int i = 0; i < 16; i++)
		modelRegs[i] = 16'd0;
	modelFlag = 1'b0;
	modelHalted = 1'b0;
	expQ.delete();
endtask

task automatic modelStep(input logic [15:0] word);
	logic [3:0]  op;
	logic [3:0]  dst;
	logic [15:0] srcA;
	logic [15:0] srcB;
	logic [15:0] res;
	logic        doWrite;
	logic        doFlag;
	op = word[15:12];
	dst = word[11:8];
	srcA = modelRegs[word[7:4]];
	srcB = modelRegs[word[3:0]];
	res = 16'd0;
	doWrite = 1'b0;
	doFlag = 1'b0;
	if (!modelHalted) begin
		doWrite = 1'b1;
		// add, addz, sub, and, nor update the flag
		doFlag = (op <= 4'd4);
		case (op)
			4'd0: res = srcA + srcB;
			// addz commits only on a flag left set by earlier work
			4'd1: begin
				res = srcA + srcB;
				doWrite = modelFlag;
			end
			4'd2: res = srcA - srcB;
			4'd3: res = srcA & srcB;
			4'd4: res = ~(srcA | srcB);
			4'd5: res = srcA << word[3:0];
			4'd6: res = srcA >> word[3:0];
			4'd7: res = $unsigned($signed(srcA) >>> word[3:0]);
			// lhb keeps the old low byte of rd
			4'd10: res = {word[7:0], modelRegs[dst][7:0]};
			4'd11: res = {{8{word[7]}}, word[7:0]};
			4'd15: begin
				modelHalted = 1'b1;
				doWrite = 1'b0;
			end
			default: doWrite = 1'b0;
		endcase
	end
	if (doWrite) begin
		modelRegs[dst] = res;
		expQ.push_back({dst, res});
	end
	if (doFlag)
		modelFlag = (res == 16'd0);
endtask

`endif

// ==== verif/cpuCoreTb.sv ====
/*
 * Testbench for cpuCore with a random instruction stream from a credit-tracking
 * driver and every writeback checked in order against the reference model
 */
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module cpuCoreTb;

	import isaPkg::*;
	import pipePkg::*;

	localparam int NumRandom = 300;
	localparam int NumAddzSeq = 30;
	localparam int NumAfterHalt = 3;
	localparam int NumInstr = NumRandom + 3 * NumAddzSeq + 1 + NumAfterHalt;

	logic      clk;
	logic      reset;
	logic      instrValid;
	instrWordT instr;
	logic      creditReturn;
	logic      halted;
	wbPortT    wbOut;

	logic [31:0] rngState;
	logic [31:0] r;
	logic [3:0]  lastDst;
	logic [19:0] expHead;
	int          pushedCount;
	int          returnedCount;
	int          pushedThroughHalt;
	int          checkCount;
	int          errorCount;
	logic        monitorOn;
	string       testName;

	`include "refModel.svh"

	cpuCore uut (
		.clk          (clk),
		.reset        (reset),
		.instrValid   (instrValid),
		.instr        (instr),
		.creditReturn (creditReturn),
		.halted       (halted),
		.wbOut        (wbOut)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	task automatic checkValue(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("ERROR %s: %s expected %0h, actual %0h", testName, what, expected, actual);
		end
	endtask

	task advanceCycle();
		@(posedge clk);
		#1;
	endtask

	// ALU, shift and byte-load mix with some undefined opcodes
	function logic [15:0] randomWord();
		logic [31:0] rnd;
		logic [3:0]  op;
		logic [3:0]  dst;
		logic [3:0]  src1;
		logic [3:0]  src0;
		rnd = nextRandom();
		op = rnd[31:28];
		// addz and hlt have their own phases
		if (op == 4'd1 || op == 4'd15)
			op = 4'd11;
		else if (op == 4'd12 || op == 4'd13)
			op = 4'd10;
		dst = rnd[3:0];
		// Reuse the last destination often
		src1 = rnd[4] ? lastDst : rnd[11:8];
		src0 = rnd[5] ? lastDst : rnd[15:12];
		lastDst = dst;
		if (op == 4'd10 || op == 4'd11)
			return {op, dst, rnd[23:16]};
		return {op, dst, src1, src0};
	endfunction

	task pushInstr(input logic [15:0] word);
		logic [31:0] pauseRnd;
		pauseRnd = nextRandom();
		// Short idle gap between bursts now and then
		if (pauseRnd[1:0] == 2'b00) begin
			instrValid = 1'b0;
			repeat (int'(pauseRnd[3:2]) + 1)
				advanceCycle();
		end
		// Hold the instruction while no credit is left
		while (pushedCount - returnedCount >= `CORE_QUEUE_DEPTH) begin
			instrValid = 1'b0;
			advanceCycle();
		end
		instrValid = 1'b1;
		instr = word;
		pushedCount++;
		modelStep(word);
		advanceCycle();
	endtask

	// Credit and writeback monitor sampling mid-cycle
	always @(negedge clk) begin
		if (monitorOn) begin
			if (creditReturn)
				returnedCount++;
			if (returnedCount > pushedCount ||
					pushedCount - returnedCount > `CORE_QUEUE_DEPTH) begin
				errorCount++;
				$display("Sender credit count left the range 0 to queue depth");
			end
			if (halted) begin
				checkValue("creditReturn after halt", 32'd0, 32'(creditReturn));
				checkValue("writeback after halt", 32'd0, 32'(wbOut.valid));
			end else if (wbOut.valid) begin
				if (expQ.size() == 0) begin
					errorCount++;
					$display("Writeback to r%0d arrived when none was expected", wbOut.addr);
				end else begin
					expHead = expQ.pop_front();
					checkValue("writeback address", 32'(expHead[19:16]), 32'(wbOut.addr));
					checkValue("writeback data", 32'(expHead[15:0]), 32'(wbOut.data));
				end
			end
		end
	end

	initial begin
		repeat ((NumInstr + 50) * 4) @(posedge clk);
		$display("Watchdog expired after %0d cycles without the run finishing",
			(NumInstr + 50) * 4);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		rngState = 32'd45942;
		lastDst = 4'd0;
		pushedCount = 0;
		returnedCount = 0;
		pushedThroughHalt = 0;
		checkCount = 0;
		errorCount = 0;
		monitorOn = 1'b0;
		testName = "reset";
		modelReset();
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		monitorOn = 1'b1;
		// Outputs stay quiet before the first push
		repeat (3) begin
			@(negedge clk);
			checkValue("creditReturn", 32'd0, 32'(creditReturn));
			checkValue("halted", 32'd0, 32'(halted));
			checkValue("writeback valid", 32'd0, 32'(wbOut.valid));
		end
		advanceCycle();

		testName = "random mix";
		for (int i = 0; i < NumRandom; i++)
			pushInstr(randomWord());

		// llb loads a nonzero value, then sub x-x sets the flag or and clears it
		testName = "addz flag";
		for (int i = 0; i < NumAddzSeq; i++) begin
			r = nextRandom();
			pushInstr({4'd11, r[3:0], r[23:16] | 8'h01});
			if (r[31])
				pushInstr({4'd2, r[7:4], r[11:8], r[11:8]});
			else
				pushInstr({4'd3, r[7:4], r[3:0], r[3:0]});
			pushInstr({4'd1, r[15:12], r[27:24], r[3:0]});
		end

		testName = "credit idle";
		instrValid = 1'b0;
		// A full queue drains within a few cycles
		for (int w = 0; w < 4 * `CORE_QUEUE_DEPTH && returnedCount != pushedCount; w++)
			advanceCycle();
		repeat (2) advanceCycle();
		checkValue("writebacks left", 32'd0, 32'(expQ.size()));
		checkValue("credits back at idle", 32'(pushedCount), 32'(returnedCount));

		testName = "halt";
		pushInstr(16'hF000);
		pushedThroughHalt = pushedCount;
		for (int i = 0; i < NumAfterHalt; i++)
			pushInstr(randomWord());
		instrValid = 1'b0;
		for (int w = 0; w < 4 * `CORE_QUEUE_DEPTH && !halted; w++)
			advanceCycle();
		repeat (8) advanceCycle();
		checkValue("credits through hlt", 32'(pushedThroughHalt), 32'(returnedCount));
		checkValue("writebacks left", 32'd0, 32'(expQ.size()));
		checkValue("halted held", 32'd1, 32'(halted));

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/cpuCore.sv ====
/*
 * Top of the execution core
 * Queue, decode, register file and execute
 */
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module cpuCore (
	input  wire logic           clk,
	input  wire logic           reset,
	input  wire logic           instrValid,
	input  isaPkg::instrWordT   instr,
	output logic                creditReturn,
	output logic                halted,
	output pipePkg::wbPortT     wbOut
);

	import isaPkg::*;
	import pipePkg::*;

	instrWordT   popData;
	logic        popValid;
	logic        pop;
	decodedCtrlT ctrl;

	logic [$clog2(`CORE_NUM_REGS)-1:0] rdAddr0;
	logic [$clog2(`CORE_NUM_REGS)-1:0] rdAddr1;
	logic [`CORE_DATA_WIDTH-1:0]       rdData0;
	logic [`CORE_DATA_WIDTH-1:0]       rdData1;

	instrQueue queue (
		.clk          (clk),
		.reset        (reset),
		.instrValid   (instrValid),
		.instr        (instr),
		.pop          (pop),
		.popValid     (popValid),
		.popData      (popData),
		.creditReturn (creditReturn)
	);

	instrDecode decode (
		.clk      (clk),
		.reset    (reset),
		.popValid (popValid),
		.popData  (popData),
		.pop      (pop),
		.rdAddr0  (rdAddr0),
		.rdAddr1  (rdAddr1),
		.ctrl     (ctrl),
		.halted   (halted)
	);

	// Execute writeback doubles as the register write port
	regFile regs (
		.clk     (clk),
		.reset   (reset),
		.rdAddr0 (rdAddr0),
		.rdAddr1 (rdAddr1),
		.rdData0 (rdData0),
		.rdData1 (rdData1),
		.wb      (wbOut)
	);

	aluExec exec (
		.clk     (clk),
		.reset   (reset),
		.ctrl    (ctrl),
		.rdData0 (rdData0),
		.rdData1 (rdData1),
		.wb      (wbOut)
	);

endmodule

`default_nettype wire

// ==== rtl/aluExec.sv ====
/*
 * Execute stage with the ALU, the zero flag and the writeback decision
 * Writeback leaves combinationally in the execute cycle
 */
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module aluExec (
	input  wire logic                        clk,
	input  wire logic                        reset,
	input  pipePkg::decodedCtrlT             ctrl,
	input  wire logic [`CORE_DATA_WIDTH-1:0] rdData0,
	input  wire logic [`CORE_DATA_WIDTH-1:0] rdData1,
	output pipePkg::wbPortT                  wb
);

	import isaPkg::*;

	localparam int Width = `CORE_DATA_WIDTH;

	logic [Width-1:0] immExt;
	logic [Width-1:0] opA;
	logic [Width-1:0] opB;
	logic [Width-1:0] result;
	logic             zero;
	logic             zeroFlag;
	logic             writeEn;

	// Sign-extended llb value
	assign immExt = {{(Width - 8){ctrl.imm8[7]}}, ctrl.imm8};

	assign opA = ctrl.useImm ? immExt : rdData1;
	assign opB = rdData0;

	always_comb begin
		case (ctrl.func)
			aluAdd: result = opA + opB;
			aluSub: result = opA - opB;
			aluAnd: result = opA & opB;
			aluNor: result = ~(opA | opB);
			aluSll: result = opA << ctrl.shamt;
			aluSrl: result = opA >> ctrl.shamt;
			aluSra: result = $unsigned($signed(opA) >>> ctrl.shamt);
			// New high byte over the old low byte of rd
			aluLhb: result = {ctrl.imm8, rdData1[7:0]};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

	// Flag holds across shifts, lhb, llb and no-ops
	always_ff @(posedge clk) begin
		if (reset)
			zeroFlag <= 1'b0;
		else if (ctrl.valid && ctrl.setsZero)
			zeroFlag <= zero;
	end

	// addz only commits when the earlier flag is set
	assign writeEn = ctrl.valid & ctrl.writes & (~ctrl.isAddz | zeroFlag);

	always_comb begin
		wb.valid = writeEn;
		wb.addr = ctrl.dst;
		wb.data = result;
	end

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
/*
 * Register file with 16 entries, two synchronous read ports
 * and one write port with write-first forwarding
 */
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module regFile (
	input  wire logic                                clk,
	input  wire logic                                reset,
	input  wire logic [$clog2(`CORE_NUM_REGS)-1:0]   rdAddr0,
	input  wire logic [$clog2(`CORE_NUM_REGS)-1:0]   rdAddr1,
	output logic [`CORE_DATA_WIDTH-1:0]              rdData0,
	output logic [`CORE_DATA_WIDTH-1:0]              rdData1,
	input  pipePkg::wbPortT                          wb
);

	logic [`CORE_DATA_WIDTH-1:0] regs [`CORE_NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CORE_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb.valid) begin
			regs[wb.addr] <= wb.data;
		end
	end

	// Same-cycle write wins over the stored value
	always_ff @(posedge clk) begin
		rdData0 <= (wb.valid && wb.addr == rdAddr0) ? wb.data : regs[rdAddr0];
		rdData1 <= (wb.valid && wb.addr == rdAddr1) ? wb.data : regs[rdAddr1];
	end

endmodule

`default_nettype wire

// ==== rtl/instrDecode.sv ====
/*
 * Decode stage that picks register read addresses, registers
 * the control word for execute and tracks the halt state
 */
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module instrDecode (
	input  wire logic                                clk,
	input  wire logic                                reset,
	input  wire logic                                popValid,
	input  isaPkg::instrWordT                        popData,
	output logic                                     pop,
	output logic [$clog2(`CORE_NUM_REGS)-1:0]        rdAddr0,
	output logic [$clog2(`CORE_NUM_REGS)-1:0]        rdAddr1,
	output pipePkg::decodedCtrlT                     ctrl,
	output logic                                     halted
);

	import isaPkg::*;
	import pipePkg::*;

	decodedCtrlT ctrlNext;
	logic        isHlt;

	assign pop = popValid & ~halted;

	always_comb begin
		ctrlNext = '0;
		ctrlNext.valid = pop;
		ctrlNext.dst = popData.rFmt.dst;
		ctrlNext.shamt = popData.rFmt.src0;
		ctrlNext.imm8 = popData.iFmt.imm8;
		rdAddr0 = popData.rFmt.src0;
		rdAddr1 = popData.rFmt.src1;
		isHlt = 1'b0;
		case (popData.rFmt.opcode)
			opAdd: begin
				ctrlNext.func = aluAdd;
				ctrlNext.setsZero = 1'b1;
				ctrlNext.writes = 1'b1;
			end
			opAddz: begin
				ctrlNext.func = aluAdd;
				ctrlNext.isAddz = 1'b1;
				ctrlNext.setsZero = 1'b1;
				ctrlNext.writes = 1'b1;
			end
			opSub: begin
				ctrlNext.func = aluSub;
				ctrlNext.setsZero = 1'b1;
				ctrlNext.writes = 1'b1;
			end
			opAnd: begin
				ctrlNext.func = aluAnd;
				ctrlNext.setsZero = 1'b1;
				ctrlNext.writes = 1'b1;
			end
			opNor: begin
				ctrlNext.func = aluNor;
				ctrlNext.setsZero = 1'b1;
				ctrlNext.writes = 1'b1;
			end
			opSll: begin
				ctrlNext.func = aluSll;
				ctrlNext.writes = 1'b1;
			end
			opSrl: begin
				ctrlNext.func = aluSrl;
				ctrlNext.writes = 1'b1;
			end
			opSra: begin
				ctrlNext.func = aluSra;
				ctrlNext.writes = 1'b1;
			end
			opLhb: begin
				// Port 1 fetches rd so its low byte survives
				ctrlNext.func = aluLhb;
				ctrlNext.useImm = 1'b1;
				ctrlNext.writes = 1'b1;
				rdAddr1 = popData.iFmt.dst;
			end
			opLlb: begin
				// Immediate through the shifter with zero shift
				ctrlNext.func = aluSll;
				ctrlNext.shamt = 4'd0;
				ctrlNext.useImm = 1'b1;
				ctrlNext.writes = 1'b1;
			end
			opHlt: isHlt = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl <= '0;
			halted <= 1'b0;
		end else begin
			ctrl <= ctrlNext;
			if (pop && isHlt)
				halted <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/instrQueue.sv ====
/*
 * Instruction FIFO fed by a credit-controlled sender
 * Returns one credit for every entry popped
 */
`timescale 1ns/10ps
`default_nettype none

`include "core_params.svh"

module instrQueue (
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic              instrValid,
	input  isaPkg::instrWordT      instr,
	input  wire logic              pop,
	output logic                   popValid,
	output isaPkg::instrWordT      popData,
	output logic                   creditReturn
);

	import isaPkg::*;

	localparam int Depth = `CORE_QUEUE_DEPTH;
	localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CntW = $clog2(Depth + 1);

	instrWordT mem [Depth];

	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [CntW-1:0] count;
	logic            doPush;
	logic            doPop;

	function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] p);
		return (p == PtrW'(Depth - 1)) ? '0 : p + 1'b1;
	endfunction

	// Credits keep the sender from overrunning the queue
	assign doPush = instrValid;
	assign doPop = pop & popValid;

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			count <= count + CntW'(doPush) - CntW'(doPop);
		end
	end

	always_ff @(posedge clk) begin
		if (doPush)
			mem[wrPtr] <= instr;
	end

	assign popValid = (count != '0);
	assign popData = mem[rdPtr];

	// Credit goes back in the pop cycle
	assign creditReturn = doPop;

endmodule

`default_nettype wire

// ==== rtl/pipePkg.sv ====
/*
 * Pipeline types passed between decode, execute and writeback
 */
`default_nettype none

`include "core_params.svh"

package pipePkg;

	import isaPkg::*;

	// Control word handed from decode to execute
	typedef struct packed {
		logic       valid;
		aluFuncT    func;
		logic [3:0] dst;
		logic [3:0] shamt;
		logic [7:0] imm8;
		logic       useImm;
		logic       isAddz;
		logic       setsZero;
		logic       writes;
	} decodedCtrlT;

	// Writeback report that doubles as the register file write port
	typedef struct packed {
		logic                               valid;
		logic [$clog2(`CORE_NUM_REGS)-1:0]  addr;
		logic [`CORE_DATA_WIDTH-1:0]        data;
	} wbPortT;

endpackage

`default_nettype wire

// ==== rtl/isaPkg.sv ====
/*
 * ISA definitions with opcode encodings, ALU function codes
 * and the two views of an instruction word
 */
`default_nettype none

package isaPkg;

	// Opcode encodings with undefined gaps at 8, 9, 12, 13 and 14
	typedef enum logic [3:0] {
		opAdd  = 4'b0000,
		opAddz = 4'b0001,
		opSub  = 4'b0010,
		opAnd  = 4'b0011,
		opNor  = 4'b0100,
		opSll  = 4'b0101,
		opSrl  = 4'b0110,
		opSra  = 4'b0111,
		opLhb  = 4'b1010,
		opLlb  = 4'b1011,
		opHlt  = 4'b1111
	} opcodeT;

	// ALU function select
	typedef enum logic [2:0] {
		aluAdd = 3'b000,
		aluSub = 3'b001,
		aluAnd = 3'b010,
		aluNor = 3'b011,
		aluSll = 3'b100,
		aluSrl = 3'b101,
		aluLhb = 3'b110,
		aluSra = 3'b111
	} aluFuncT;

	// Register form
	typedef struct packed {
		opcodeT     opcode;
		logic [3:0] dst;
		logic [3:0] src1;
		logic [3:0] src0;
	} rFmtT;

	// Immediate form, used by lhb and llb
	typedef struct packed {
		opcodeT     opcode;
		logic [3:0] dst;
		logic [7:0] imm8;
	} iFmtT;

	typedef union packed {
		rFmtT rFmt;
		iFmtT iFmt;
	} instrWordT;

endpackage

`default_nettype wire

// ==== rtl/core_params.svh ====
/*
 * Core-wide sizing constants for the 16-bit execution core
 */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath word width
`define CORE_DATA_WIDTH 16

// Architectural register count
`define CORE_NUM_REGS 16

// Instruction queue entries
// The sender starts out with this many credits
`define CORE_QUEUE_DEPTH 4

`endif
